// ==== include/dsp_macros.svh ====
`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// Datapath sizes
`define DSP_LANES      4
`define DSP_CODE_W     8
`define DSP_COEF_W     8
`define DSP_FFE_TAPS   3
`define DSP_CHAN_TAPS  2
`define DSP_FFE_W      18
`define DSP_EST_W      10
`define DSP_ERR_W      11
`define DSP_SHIFT_W    4

// Register map, byte addresses
`define DSP_AXI_AW        8
`define DSP_REG_W0        8'h00
`define DSP_REG_W1        8'h04
`define DSP_REG_W2        8'h08
`define DSP_REG_FFE_SHIFT 8'h0C
`define DSP_REG_THRESH    8'h10
`define DSP_REG_CH0       8'h14
`define DSP_REG_CH1       8'h18
`define DSP_REG_CH_SHIFT  8'h1C

`endif

// ==== hdl/dsp_pkg.sv ====
`default_nettype none

`include "dsp_macros.svh"

package dsp_pkg;

    typedef logic signed [`DSP_CODE_W-1:0] code_t;

    // Lane 0 sits in the low bits and is the oldest sample
    typedef code_t [`DSP_LANES-1:0] code_word_t;

    typedef logic signed [`DSP_COEF_W-1:0] coef_t;
    typedef logic [`DSP_SHIFT_W-1:0] shift_t;
    typedef logic signed [`DSP_FFE_W-1:0] ffe_t;

    typedef logic [`DSP_LANES-1:0] bit_word_t;

    typedef logic signed [`DSP_ERR_W-1:0] err_t;
    typedef err_t [`DSP_LANES-1:0] err_word_t;

endpackage : dsp_pkg

`default_nettype wire

// ==== hdl/dsp_cfg_if.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "dsp_macros.svh"

interface dsp_cfg_if;

    dsp_pkg::coef_t  weights [`DSP_FFE_TAPS];
    dsp_pkg::shift_t ffe_shift;
    dsp_pkg::ffe_t   thresh;
    dsp_pkg::coef_t  chan_est [`DSP_CHAN_TAPS];
    dsp_pkg::shift_t chan_shift;

    modport regs (
        output weights, ffe_shift, thresh, chan_est, chan_shift
    );

    modport dsp (
        input weights, ffe_shift, thresh, chan_est, chan_shift
    );

endinterface : dsp_cfg_if

`default_nettype wire

// ==== hdl/tap_delay_line.sv ====
`default_nettype none
`timescale 1ns/1ns

module tap_delay_line #(
    parameter type word_t = logic [7:0],
    parameter int  depth  = 1
) (
    input  wire logic clk,
    input  wire logic rst_n_i,
    input  word_t     word_i,
    output word_t     taps_o [depth]
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < depth; i++) begin
                taps_o[i] <= '0;
            end
        end else begin
            taps_o[0] <= word_i;
            for (int i = 1; i < depth; i++) begin
                taps_o[i] <= taps_o[i-1];
            end
        end
    end

    // Each tap holds what the tap before it held one cycle earlier
    assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> taps_o[0] == $past(word_i));

    for (genvar gi = 1; gi < depth; gi++) begin : g_shift_chk
        assert property (@(posedge clk) disable iff (!rst_n_i)
            $past(rst_n_i) |-> taps_o[gi] == $past(taps_o[gi-1]));
    end

endmodule : tap_delay_line

`default_nettype wire

// ==== hdl/ffe_slicer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "dsp_macros.svh"

module ffe_slicer (
    input  wire logic          clk,
    input  wire logic          rst_n_i,
    dsp_cfg_if.dsp             cfg,
    input  dsp_pkg::code_word_t codes_cur_i,
    input  dsp_pkg::code_word_t codes_prev_i,
    output dsp_pkg::bit_word_t  bits_o
);

    // Previous word followed by current word, oldest sample first
    dsp_pkg::code_t     win [2*`DSP_LANES];
    dsp_pkg::ffe_t      sum [`DSP_LANES];
    dsp_pkg::ffe_t      y   [`DSP_LANES];
    dsp_pkg::bit_word_t bits_d;

    always_comb begin
        for (int i = 0; i < `DSP_LANES; i++) begin
            win[i]              = codes_prev_i[i];
            win[`DSP_LANES + i] = codes_cur_i[i];
        end
    end

    // Tap k looks k samples back, crossing into the previous word for low lanes
    always_comb begin
        for (int l = 0; l < `DSP_LANES; l++) begin
            sum[l] = '0;
            for (int k = 0; k < `DSP_FFE_TAPS; k++) begin
                sum[l] = sum[l] +
                    dsp_pkg::ffe_t'(win[`DSP_LANES + l - k] * cfg.weights[k]);
            end
            y[l] = sum[l] >>> cfg.ffe_shift;
        end
    end

    // Slicer
    always_comb begin
        for (int l = 0; l < `DSP_LANES; l++) begin
            bits_d[l] = (y[l] >= cfg.thresh);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= bits_d;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(bits_o));

endmodule : ffe_slicer

`default_nettype wire

// ==== hdl/channel_error.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "dsp_macros.svh"

module channel_error (
    input  wire logic           clk,
    input  wire logic           rst_n_i,
    dsp_cfg_if.dsp              cfg,
    input  dsp_pkg::bit_word_t  bits_i,
    input  dsp_pkg::code_word_t codes_i,
    output dsp_pkg::err_word_t  err_o
);

    dsp_pkg::bit_word_t           bits_prev [1];
    logic [2*`DSP_LANES-1:0]      bit_win;
    logic signed [`DSP_EST_W-1:0] est_sum [`DSP_LANES];
    logic signed [`DSP_EST_W-1:0] est     [`DSP_LANES];
    dsp_pkg::err_word_t           err_d;

    tap_delay_line #(
        .word_t (dsp_pkg::bit_word_t),
        .depth  (1)
    ) bit_dly (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .word_i  (bits_i),
        .taps_o  (bits_prev)
    );

    assign bit_win = {bits_i, bits_prev[0]};

    // Bit 1 adds the tap, bit 0 subtracts it
    always_comb begin
        logic signed [`DSP_EST_W-1:0] tap;
        dsp_pkg::code_t               code;
        for (int l = 0; l < `DSP_LANES; l++) begin
            est_sum[l] = '0;
            for (int k = 0; k < `DSP_CHAN_TAPS; k++) begin
                tap = cfg.chan_est[k];
                est_sum[l] = bit_win[`DSP_LANES + l - k] ? est_sum[l] + tap
                                                         : est_sum[l] - tap;
            end
            est[l]   = est_sum[l] >>> cfg.chan_shift;
            code     = codes_i[l];
            err_d[l] = dsp_pkg::err_t'(est[l]) - dsp_pkg::err_t'(code);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_o <= '0;
        end else begin
            err_o <= err_d;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(err_o));

endmodule : channel_error

`default_nettype wire

// ==== hdl/dsp_cfg_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "dsp_macros.svh"

module dsp_cfg_regs (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    dsp_cfg_if.regs                     cfg,
    input  wire logic [`DSP_AXI_AW-1:0] s_axi_awaddr_i,
    input  wire logic                   s_axi_awvalid_i,
    output logic                        s_axi_awready_o,
    input  wire logic [31:0]            s_axi_wdata_i,
    input  wire logic [3:0]             s_axi_wstrb_i,
    input  wire logic                   s_axi_wvalid_i,
    output logic                        s_axi_wready_o,
    output logic [1:0]                  s_axi_bresp_o,
    output logic                        s_axi_bvalid_o,
    input  wire logic                   s_axi_bready_i,
    input  wire logic [`DSP_AXI_AW-1:0] s_axi_araddr_i,
    input  wire logic                   s_axi_arvalid_i,
    output logic                        s_axi_arready_o,
    output logic [31:0]                 s_axi_rdata_o,
    output logic [1:0]                  s_axi_rresp_o,
    output logic                        s_axi_rvalid_o,
    input  wire logic                   s_axi_rready_i
);

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic        out_of_rst_q;
    logic        wr_go;
    logic        rd_go;
    logic        rd_ok;
    logic [31:0] rd_data;

    // Holds the ready outputs low until the first cycle after reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_of_rst_q <= 1'b0;
        end else begin
            out_of_rst_q <= 1'b1;
        end
    end

    assign wr_go = out_of_rst_q && s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
    assign s_axi_awready_o = wr_go;
    assign s_axi_wready_o  = wr_go;
    assign s_axi_arready_o = out_of_rst_q && !s_axi_rvalid_o;
    assign rd_go = s_axi_arvalid_i && s_axi_arready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg.weights[0] <= dsp_pkg::coef_t'(1);
            cfg.weights[1] <= '0;
            cfg.weights[2] <= '0;
            cfg.ffe_shift  <= '0;
            cfg.thresh     <= '0;
            cfg.chan_est[0] <= dsp_pkg::coef_t'(1);
            cfg.chan_est[1] <= '0;
            cfg.chan_shift <= '0;
        end else if (wr_go) begin
            case (s_axi_awaddr_i)
                `DSP_REG_W0:        cfg.weights[0]  <= s_axi_wdata_i[`DSP_COEF_W-1:0];
                `DSP_REG_W1:        cfg.weights[1]  <= s_axi_wdata_i[`DSP_COEF_W-1:0];
                `DSP_REG_W2:        cfg.weights[2]  <= s_axi_wdata_i[`DSP_COEF_W-1:0];
                `DSP_REG_FFE_SHIFT: cfg.ffe_shift   <= s_axi_wdata_i[`DSP_SHIFT_W-1:0];
                `DSP_REG_THRESH:    cfg.thresh      <= s_axi_wdata_i[`DSP_FFE_W-1:0];
                `DSP_REG_CH0:       cfg.chan_est[0] <= s_axi_wdata_i[`DSP_COEF_W-1:0];
                `DSP_REG_CH1:       cfg.chan_est[1] <= s_axi_wdata_i[`DSP_COEF_W-1:0];
                `DSP_REG_CH_SHIFT:  cfg.chan_shift  <= s_axi_wdata_i[`DSP_SHIFT_W-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s_axi_bvalid_o <= 1'b0;
            s_axi_rvalid_o <= 1'b0;
        end else begin
            if (wr_go) begin
                s_axi_bvalid_o <= 1'b1;
            end else if (s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end
            if (rd_go) begin
                s_axi_rvalid_o <= 1'b1;
            end else if (s_axi_rready_i) begin
                s_axi_rvalid_o <= 1'b0;
            end
        end
    end

    // Readback, signed fields sign-extended
    always_comb begin
        rd_ok   = 1'b1;
        rd_data = '0;
        case (s_axi_araddr_i)
            `DSP_REG_W0:        rd_data = 32'(cfg.weights[0]);
            `DSP_REG_W1:        rd_data = 32'(cfg.weights[1]);
            `DSP_REG_W2:        rd_data = 32'(cfg.weights[2]);
            `DSP_REG_FFE_SHIFT: rd_data = 32'(cfg.ffe_shift);
            `DSP_REG_THRESH:    rd_data = 32'(cfg.thresh);
            `DSP_REG_CH0:       rd_data = 32'(cfg.chan_est[0]);
            `DSP_REG_CH1:       rd_data = 32'(cfg.chan_est[1]);
            `DSP_REG_CH_SHIFT:  rd_data = 32'(cfg.chan_shift);
            default:            rd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            case (s_axi_awaddr_i)
                `DSP_REG_W0, `DSP_REG_W1, `DSP_REG_W2, `DSP_REG_FFE_SHIFT,
                `DSP_REG_THRESH, `DSP_REG_CH0, `DSP_REG_CH1, `DSP_REG_CH_SHIFT:
                    s_axi_bresp_o <= resp_okay;
                default:
                    s_axi_bresp_o <= resp_slverr;
            endcase
        end
        if (rd_go) begin
            s_axi_rdata_o <= rd_data;
            s_axi_rresp_o <= rd_ok ? resp_okay : resp_slverr;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

    assert property (@(posedge clk) disable iff (!rst_n_i)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o));

endmodule : dsp_cfg_regs

`default_nettype wire

// ==== hdl/dsp_datapath_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "dsp_macros.svh"

module dsp_datapath_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  dsp_pkg::code_word_t         adc_codes_i,
    output dsp_pkg::bit_word_t          bits_o,
    output dsp_pkg::err_word_t          err_o,
    input  wire logic [`DSP_AXI_AW-1:0] s_axi_awaddr_i,
    input  wire logic                   s_axi_awvalid_i,
    output logic                        s_axi_awready_o,
    input  wire logic [31:0]            s_axi_wdata_i,
    input  wire logic [3:0]             s_axi_wstrb_i,
    input  wire logic                   s_axi_wvalid_i,
    output logic                        s_axi_wready_o,
    output logic [1:0]                  s_axi_bresp_o,
    output logic                        s_axi_bvalid_o,
    input  wire logic                   s_axi_bready_i,
    input  wire logic [`DSP_AXI_AW-1:0] s_axi_araddr_i,
    input  wire logic                   s_axi_arvalid_i,
    output logic                        s_axi_arready_o,
    output logic [31:0]                 s_axi_rdata_o,
    output logic [1:0]                  s_axi_rresp_o,
    output logic                        s_axi_rvalid_o,
    input  wire logic                   s_axi_rready_i
);

    dsp_pkg::code_word_t code_taps [1];

    dsp_cfg_if cfg_if ();

    dsp_cfg_regs cfg_regs (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .cfg             (cfg_if.regs),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i)
    );

    // Previous word for the FFE window, also aligned with the registered bits
    tap_delay_line #(
        .word_t (dsp_pkg::code_word_t),
        .depth  (1)
    ) code_dly (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .word_i  (adc_codes_i),
        .taps_o  (code_taps)
    );

    ffe_slicer ffe (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cfg          (cfg_if.dsp),
        .codes_cur_i  (adc_codes_i),
        .codes_prev_i (code_taps[0]),
        .bits_o       (bits_o)
    );

    channel_error chan_err (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .cfg     (cfg_if.dsp),
        .bits_i  (bits_o),
        .codes_i (code_taps[0]),
        .err_o   (err_o)
    );

endmodule : dsp_datapath_top

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Released just after the eighth rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

// ==== tb/tb_dsp_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "dsp_macros.svh"

module tb_dsp_top;

    localparam int wait_limit   = 50;
    localparam int flag_awready = 0;
    localparam int flag_bvalid  = 1;
    localparam int flag_arready = 2;
    localparam int flag_rvalid  = 3;

    logic                clk;
    logic                rst_n;
    dsp_pkg::code_word_t adc_codes;
    dsp_pkg::bit_word_t  bits;
    dsp_pkg::err_word_t  err;

    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // Bench copy of the registers, indexed by address / 4
    logic [31:0] reg_exp [8] = '{32'd1, 32'd0, 32'd0, 32'd0, 32'd0, 32'd1, 32'd0, 32'd0};

    // Sample history, index 0 newest
    int   code_h [3] = '{0, 0, 0};
    logic bit_h  [2] = '{1'b0, 1'b0};

    dsp_pkg::bit_word_t pend_bits;
    dsp_pkg::bit_word_t chk_bits;
    dsp_pkg::err_word_t pend_err;
    dsp_pkg::err_word_t pend2_err;
    dsp_pkg::err_word_t chk_err;
    logic pend_bits_en  = 1'b0;
    logic chk_bits_en   = 1'b0;
    logic pend_err_en   = 1'b0;
    logic pend2_err_en  = 1'b0;
    logic chk_err_en    = 1'b0;

    int    seed = 51867;
    int    stream_mode = 0;
    int    mode_q;
    int    errors = 0;
    int    errs_at_start = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    string test_name = "reset_state";

    tb_clk_gen clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dsp_datapath_top dut0 (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .adc_codes_i     (adc_codes),
        .bits_o          (bits),
        .err_o           (err),
        .s_axi_awaddr_i  (awaddr),
        .s_axi_awvalid_i (awvalid),
        .s_axi_awready_o (awready),
        .s_axi_wdata_i   (wdata),
        .s_axi_wstrb_i   (wstrb),
        .s_axi_wvalid_i  (wvalid),
        .s_axi_wready_o  (wready),
        .s_axi_bresp_o   (bresp),
        .s_axi_bvalid_o  (bvalid),
        .s_axi_bready_i  (bready),
        .s_axi_araddr_i  (araddr),
        .s_axi_arvalid_i (arvalid),
        .s_axi_arready_o (arready),
        .s_axi_rdata_o   (rdata),
        .s_axi_rresp_o   (rresp),
        .s_axi_rvalid_o  (rvalid),
        .s_axi_rready_i  (rready)
    );

    assert property (@(posedge clk) !rst_n |->
        bits == '0 && err == '0 && !bvalid && !rvalid && !awready && !wready && !arready)
        else begin
            $display("Outputs were not idle while reset was asserted");
            errors++;
        end

    assert property (@(posedge clk) chk_bits_en |-> bits == chk_bits)
        else begin
            $display("Fail %s bits_o expected %h actual %h",
                     test_name, $sampled(chk_bits), $sampled(bits));
            errors++;
        end

    assert property (@(posedge clk) chk_err_en |-> err == chk_err)
        else begin
            $display("Fail %s err_o expected %h actual %h",
                     test_name, $sampled(chk_err), $sampled(err));
            errors++;
        end

    function automatic logic [31:0] field_value(input int idx, input logic [31:0] data);
        case (idx)
            3, 7:    return {{(32-`DSP_SHIFT_W){1'b0}}, data[`DSP_SHIFT_W-1:0]};
            4:       return {{(32-`DSP_FFE_W){data[`DSP_FFE_W-1]}}, data[`DSP_FFE_W-1:0]};
            default: return {{(32-`DSP_COEF_W){data[`DSP_COEF_W-1]}}, data[`DSP_COEF_W-1:0]};
        endcase
    endfunction

    function automatic logic axi_flag(input int sel);
        case (sel)
            flag_awready: return awready;
            flag_bvalid:  return bvalid;
            flag_arready: return arready;
            default:      return rvalid;
        endcase
    endfunction

    // Next word plus the reference model, one sample at a time
    task automatic drive_word(input int mode);
        dsp_pkg::code_word_t w;
        dsp_pkg::bit_word_t  nb;
        dsp_pkg::err_word_t  ne;
        int y;
        int est;
        for (int l = 0; l < `DSP_LANES; l++) begin
            w[l] = (mode != 0) ? dsp_pkg::code_t'($random(seed)) : dsp_pkg::code_t'(0);
            code_h[2] = code_h[1];
            code_h[1] = code_h[0];
            code_h[0] = w[l];
            y = 0;
            for (int k = 0; k < `DSP_FFE_TAPS; k++) begin
                y += $signed(reg_exp[k]) * code_h[k];
            end
            y = y >>> reg_exp[3][`DSP_SHIFT_W-1:0];
            nb[l] = (y >= $signed(reg_exp[4]));
            bit_h[1] = bit_h[0];
            bit_h[0] = nb[l];
            est = 0;
            for (int k = 0; k < `DSP_CHAN_TAPS; k++) begin
                est += bit_h[k] ? $signed(reg_exp[5+k]) : -$signed(reg_exp[5+k]);
            end
            est = est >>> reg_exp[7][`DSP_SHIFT_W-1:0];
            ne[l] = dsp_pkg::err_t'(est - code_h[0]);
        end
        adc_codes    = w;
        chk_bits     = pend_bits;
        chk_bits_en  = pend_bits_en;
        chk_err      = pend2_err;
        chk_err_en   = pend2_err_en;
        pend2_err    = pend_err;
        pend2_err_en = pend_err_en;
        pend_err     = ne;
        pend_err_en  = (mode == 2);
        pend_bits    = nb;
        pend_bits_en = (mode != 0);
    endtask

    always @(posedge clk) begin
        mode_q = stream_mode;
        #1;
        drive_word(mode_q);
    end

    task automatic abort_run(input string what);
        $display("Timeout waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Returns at a falling edge with the flag high
    task automatic wait_flag(input int sel, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (axi_flag(sel) !== 1'b1) begin
            if (n == wait_limit) abort_run(what);
            n++;
            @(negedge clk);
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        wait_flag(flag_awready, "write accept");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_flag(flag_bvalid, "write response");
        resp = bresp;
        next_cycle();
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        wait_flag(flag_arready, "read accept");
        next_cycle();
        arvalid = 1'b0;
        wait_flag(flag_rvalid, "read data");
        data = rdata;
        resp = rresp;
        next_cycle();
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        logic       mapped;
        mapped = (addr[1:0] == 2'b00) && (addr < 8'h20);
        axi_write(addr, data, resp);
        check_eq("bresp", mapped ? 32'd0 : 32'd2, 32'(resp));
        if (mapped) begin
            reg_exp[addr[4:2]] = field_value(addr[4:2], data);
        end
    endtask

    task automatic read_check(input logic [7:0] addr);
        logic [1:0]  resp;
        logic [31:0] data;
        logic        mapped;
        mapped = (addr[1:0] == 2'b00) && (addr < 8'h20);
        axi_read(addr, data, resp);
        check_eq("rresp", mapped ? 32'd0 : 32'd2, 32'(resp));
        check_eq("rdata", mapped ? reg_exp[addr[4:2]] : 32'd0, data);
    endtask

    task automatic read_all();
        for (int i = 0; i < 8; i++) begin
            read_check(8'(i * 4));
        end
    endtask

    task automatic run_stream(input int mode);
        repeat (3) next_cycle();
        stream_mode = mode;
        repeat (200) @(posedge clk);
        #1;
        stream_mode = 0;
        repeat (4) next_cycle();
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errs_at_start) begin
            $display("%s passed", test_name);
            pass_cnt++;
        end else begin
            $display("%s failed with %0d errors", test_name, errors - errs_at_start);
            fail_cnt++;
        end
    endtask

    task automatic write_backpressure();
        awaddr  = `DSP_REG_W1;
        wdata   = 32'h0000_0011;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        wait_flag(flag_awready, "first write accept");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        reg_exp[1] = field_value(1, 32'h11);
        wait_flag(flag_bvalid, "first write response");
        check_eq("bresp", 32'd0, 32'(bresp));
        next_cycle();
        awaddr  = `DSP_REG_W2;
        wdata   = 32'h0000_00E2;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_eq("bvalid held", 32'd1, 32'(bvalid));
            check_eq("awready blocked", 32'd0, 32'(awready));
            check_eq("wready blocked", 32'd0, 32'(wready));
        end
        next_cycle();
        bready = 1'b1;
        wait_flag(flag_awready, "second write accept");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        reg_exp[2] = field_value(2, 32'hE2);
        wait_flag(flag_bvalid, "second write response");
        check_eq("bresp", 32'd0, 32'(bresp));
        next_cycle();
    endtask

    task automatic read_backpressure();
        logic [31:0] held;
        araddr  = `DSP_REG_W1;
        arvalid = 1'b1;
        rready  = 1'b0;
        wait_flag(flag_arready, "first read accept");
        next_cycle();
        arvalid = 1'b0;
        wait_flag(flag_rvalid, "first read data");
        held = rdata;
        check_eq("rdata", reg_exp[1], rdata);
        next_cycle();
        araddr  = `DSP_REG_CH0;
        arvalid = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_eq("rvalid held", 32'd1, 32'(rvalid));
            check_eq("rdata stable", held, rdata);
            check_eq("arready blocked", 32'd0, 32'(arready));
        end
        next_cycle();
        rready = 1'b1;
        wait_flag(flag_arready, "second read accept");
        next_cycle();
        arvalid = 1'b0;
        wait_flag(flag_rvalid, "second read data");
        check_eq("rdata", reg_exp[5], rdata);
        check_eq("rresp", 32'd0, 32'(rresp));
        next_cycle();
    endtask

    initial begin
        int n;
        adc_codes = '0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = 4'hF;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;

        n = 0;
        while (rst_n !== 1'b1) begin
            if (n == wait_limit) abort_run("reset release");
            n++;
            @(posedge clk);
        end
        #1;
        read_all();
        finish_test();

        start_test("register_access");
        write_reg(`DSP_REG_W0, 32'h1234_56F3);
        write_reg(`DSP_REG_W1, 32'h0000_0025);
        write_reg(`DSP_REG_W2, 32'hABCD_0080);
        write_reg(`DSP_REG_FFE_SHIFT, 32'h0000_0005);
        write_reg(`DSP_REG_THRESH, 32'h0003_0001);
        write_reg(`DSP_REG_CH0, 32'h0000_007F);
        write_reg(`DSP_REG_CH1, 32'hFFFF_FF9C);
        write_reg(`DSP_REG_CH_SHIFT, 32'h0000_0002);
        read_all();
        write_reg(8'h20, 32'h0000_0055);
        read_check(8'h20);
        write_reg(8'h02, 32'h0000_0066);
        read_check(8'h02);
        read_all();
        finish_test();

        start_test("ffe_slicer");
        write_reg(`DSP_REG_W0, 32'h0000_0005);
        write_reg(`DSP_REG_W1, 32'h0000_00FD);
        write_reg(`DSP_REG_W2, 32'h0000_0002);
        write_reg(`DSP_REG_FFE_SHIFT, 32'h0000_0002);
        write_reg(`DSP_REG_THRESH, 32'd12);
        run_stream(1);
        finish_test();

        start_test("channel_error");
        write_reg(`DSP_REG_CH0, 32'd40);
        write_reg(`DSP_REG_CH1, 32'h0000_00F1);
        write_reg(`DSP_REG_CH_SHIFT, 32'h0000_0001);
        run_stream(2);
        finish_test();

        start_test("response_backpressure");
        write_backpressure();
        read_check(`DSP_REG_W1);
        read_check(`DSP_REG_W2);
        read_backpressure();
        finish_test();

        $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_dsp_top

`default_nettype wire

// ==== compile.f ====
+incdir+include
hdl/dsp_pkg.sv
hdl/dsp_cfg_if.sv
hdl/tap_delay_line.sv
hdl/ffe_slicer.sv
hdl/channel_error.sv
hdl/dsp_cfg_regs.sv
hdl/dsp_datapath_top.sv
tb/tb_clk_gen.sv
tb/tb_dsp_top.sv

// ==== Bender.yml ====
package:
  name: dsp_datapath

sources:
  - include_dirs:
      - include
    files:
      - hdl/dsp_pkg.sv
      - hdl/dsp_cfg_if.sv
      - hdl/tap_delay_line.sv
      - hdl/ffe_slicer.sv
      - hdl/channel_error.sv
      - hdl/dsp_cfg_regs.sv
      - hdl/dsp_datapath_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_dsp_top.sv
